// File: source/mac_arith_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MAC arithmetic package
// Operand, product and accumulator widths of the processing element
// together with the signed data types built from them
////////////////////////////////////////////////////////////////////////////

package mac_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int OPERAND_W     = 8;               // Host operand width
  localparam int PRODUCT_W     = 2 * OPERAND_W;   // Full signed product
  localparam int ACC_W_DEFAULT = 28;              // Running sum width

  // Register stages between operand issue and product out
  localparam int mul_stages = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [OPERAND_W-1:0] operand_t;
  typedef logic signed [PRODUCT_W-1:0] product_t;

endpackage

// File: source/mac_link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MAC link package
// Payloads carried on the host input port and the sideband tag that
// follows each operand pair through the multiplier and accumulator
////////////////////////////////////////////////////////////////////////////

package mac_link_pkg;

  import mac_arith_pkg::*;

  // Sideband that travels beside the data in every pipeline stage
  typedef struct packed {
    logic valid;   // Stage holds a real item
    logic first;   // Restart the running sum
    logic last;    // Item closes its group
  } mac_tag_t;

  // One operand pair as presented by the host
  typedef struct packed {
    operand_t a;
    operand_t b;
    logic     first;
    logic     last;
  } operand_pkt_t;

endpackage

// File: source/cla4_block.sv
////////////////////////////////////////////////////////////////////////////
// 4-bit carry-lookahead block
// Sums two nibbles with lookahead carries and exports group propagate
// and generate for the next lookahead level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cla4_block (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       grp_p,
  output logic       grp_g
);

  logic [3:0] p;   // Bit propagate
  logic [3:0] g;   // Bit generate
  logic [3:0] c;   // Carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // All carries formed straight from p, g and cin
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

  // Group terms for the carry unit above
  assign grp_p = &p;
  assign grp_g = g[3]
               | (p[3] & g[2])
               | (p[3] & p[2] & g[1])
               | (p[3] & p[2] & p[1] & g[0]);

endmodule

// File: source/cla_adder.sv
////////////////////////////////////////////////////////////////////////////
// Carry-lookahead adder
// Chains 4-bit lookahead blocks, a lookahead carry unit derives each
// block carry-in from the group propagate and generate of the block below
// Width must be a multiple of four
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cla_adder #(
  parameter int width = 28
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic [width-1:0] sum
);

  localparam int n_blk = width / 4;

  logic [n_blk-1:0] blk_cin;   // Carry into each nibble

  assign blk_cin[0] = 1'b0;    // Plain addition

  for (genvar i = 0; i < n_blk; i++) begin : g_blk
    if (i < n_blk - 1) begin : g_low
      logic grp_p;
      logic grp_g;

      cla4_block u_cla4 (
        .a     (a[4*i +: 4]),
        .b     (b[4*i +: 4]),
        .cin   (blk_cin[i]),
        .sum   (sum[4*i +: 4]),
        .grp_p (grp_p),
        .grp_g (grp_g)
      );

      // Carry unit slice
      assign blk_cin[i+1] = grp_g | (grp_p & blk_cin[i]);
    end else begin : g_top
      // Top nibble has no block above it
      cla4_block u_cla4 (
        .a     (a[4*i +: 4]),
        .b     (b[4*i +: 4]),
        .cin   (blk_cin[i]),
        .sum   (sum[4*i +: 4]),
        .grp_p (),
        .grp_g ()
      );
    end
  end

endmodule

// File: source/signed_mul_pipe.sv
////////////////////////////////////////////////////////////////////////////
// Eight-stage signed 8x8 multiplier
// Multiplies operand magnitudes through a tree of split low/high half
// additions and restores the sign in the last stage
// The tag moves with the data and every stage holds while adv is low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module signed_mul_pipe (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    adv,
  input  mac_arith_pkg::operand_t a,
  input  mac_arith_pkg::operand_t b,
  input  mac_link_pkg::mac_tag_t  tag_in,
  output mac_arith_pkg::product_t prod,
  output mac_link_pkg::mac_tag_t  prod_tag
);

  import mac_arith_pkg::*;
  import mac_link_pkg::*;

  logic [OPERAND_W-1:0] a_mag;
  logic [OPERAND_W-1:0] b_mag;
  logic [OPERAND_W-1:0] pp     [OPERAND_W];   // Partial products
  logic [OPERAND_W-1:0] pp_q   [OPERAND_W];
  logic [5:0]           lsb2   [4];
  logic [5:0]           lsb2_q [4];
  logic [2:0]           hi2e_q [4];           // Upper bits of even rows
  logic [3:0]           hi2o_q [4];           // Upper bits of odd rows
  logic [4:0]           msb3   [4];
  logic [9:0]           sum3_q [4];
  logic [7:0]           lsb4   [2];
  logic [7:0]           lsb4_q [2];
  logic [2:0]           hi4e_q [2];
  logic [4:0]           hi4o_q [2];
  logic [4:0]           msb5   [2];
  logic [11:0]          sum5_q [2];
  logic [9:0]           lsb6;
  logic [9:0]           lsb6_q;
  logic [2:0]           hi6e_q;
  logic [6:0]           hi6o_q;
  logic [6:0]           msb7;
  logic [15:0]          mag_q;                // Unsigned product
  product_t             prod_q;
  logic                 sign_q [mul_stages-1];
  mac_tag_t             tag_q  [mul_stages];

  ////////////////////////////////////////////////////////////////////////////
  // Combinational part of each stage
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    a_mag = a[OPERAND_W-1] ? ~a + 1'b1 : a;
    b_mag = b[OPERAND_W-1] ? ~b + 1'b1 : b;
    for (int i = 0; i < OPERAND_W; i++) begin
      pp[i] = b_mag[i] ? a_mag : '0;
    end
    // Row pairs, odd row weighted by two
    for (int k = 0; k < 4; k++) begin
      lsb2[k] = pp_q[2*k][4:0] + {pp_q[2*k+1][3:0], 1'b0};
      msb3[k] = hi2e_q[k] + hi2o_q[k] + lsb2_q[k][5];
    end
    // Pairs of pairs, upper sum weighted by four
    for (int j = 0; j < 2; j++) begin
      lsb4[j] = sum3_q[2*j][6:0] + {sum3_q[2*j+1][4:0], 2'b0};
      msb5[j] = hi4e_q[j] + hi4o_q[j] + lsb4_q[j][7];
    end
    lsb6 = sum5_q[0][8:0] + {sum5_q[1][4:0], 4'b0};   // Weight of sixteen
    msb7 = hi6e_q + hi6o_q + lsb6_q[9];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv) begin
      pp_q      <= pp;                          // Stage 1
      sign_q[0] <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
      for (int s = 1; s < mul_stages - 1; s++) begin
        sign_q[s] <= sign_q[s-1];
      end
      lsb2_q <= lsb2;                           // Stage 2
      for (int k = 0; k < 4; k++) begin
        hi2e_q[k] <= pp_q[2*k][7:5];
        hi2o_q[k] <= pp_q[2*k+1][7:4];
        sum3_q[k] <= {msb3[k], lsb2_q[k][4:0]}; // Stage 3
      end
      lsb4_q <= lsb4;                           // Stage 4
      for (int j = 0; j < 2; j++) begin
        hi4e_q[j] <= sum3_q[2*j][9:7];
        hi4o_q[j] <= sum3_q[2*j+1][9:5];
        sum5_q[j] <= {msb5[j], lsb4_q[j][6:0]}; // Stage 5
      end
      lsb6_q <= lsb6;                           // Stage 6
      hi6e_q <= sum5_q[0][11:9];
      hi6o_q <= sum5_q[1][11:5];
      mag_q  <= {msb7, lsb6_q[8:0]};            // Stage 7
      // Stage 8 restores the sign
      prod_q <= sign_q[mul_stages-2] ? product_t'(-mag_q) : product_t'(mag_q);
    end
  end

  // Tag pipeline
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int s = 0; s < mul_stages; s++) begin
        tag_q[s] <= '0;
      end
    end else if (adv) begin
      tag_q[0] <= tag_in;
      for (int s = 1; s < mul_stages; s++) begin
        tag_q[s] <= tag_q[s-1];
      end
    end
  end

  assign prod     = prod_q;
  assign prod_tag = tag_q[mul_stages-1];

endmodule

// File: source/mac_accumulator.sv
////////////////////////////////////////////////////////////////////////////
// MAC accumulator
// Adds each valid product into the running sum through a lookahead adder
// and starts from zero on an item flagged first
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_accumulator #(
  parameter int acc_w = mac_arith_pkg::ACC_W_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    adv,
  input  mac_arith_pkg::product_t prod,
  input  mac_link_pkg::mac_tag_t  prod_tag,
  output logic signed [acc_w-1:0] acc_sum,
  output mac_link_pkg::mac_tag_t  acc_tag
);

  import mac_arith_pkg::*;
  import mac_link_pkg::*;

  typedef logic signed [acc_w-1:0] acc_t;

  acc_t     prod_ext;   // Product widened to the sum
  acc_t     addend;
  acc_t     sum_next;
  acc_t     sum_q;
  mac_tag_t tag_q;

  assign prod_ext = {{(acc_w-PRODUCT_W){prod[PRODUCT_W-1]}}, prod};
  assign addend   = prod_tag.first ? '0 : sum_q;   // Restart of a group

  // Wraps modulo 2**acc_w
  cla_adder #(
    .width (acc_w)
  ) u_add (
    .a   (prod_ext),
    .b   (addend),
    .sum (sum_next)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tag_q <= '0;
      sum_q <= '0;
    end else if (adv) begin
      tag_q <= prod_tag;
      if (prod_tag.valid) begin
        sum_q <= sum_next;
      end
    end
  end

  assign acc_sum = sum_q;
  assign acc_tag = tag_q;

  // A new item shows up only on an advancing edge
  a_valid_on_adv : assert property (@(posedge clk) disable iff (!rstn)
    $rose(acc_tag.valid) |-> $past(adv));

endmodule

// File: source/mac_flow_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// MAC flow control
// Runs the four-phase operand and result ports, issues captured pairs into
// the multiplier and freezes the pipeline while a result is pending
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mac_flow_ctrl #(
  parameter int acc_w = mac_arith_pkg::ACC_W_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       in_req,
  input  mac_link_pkg::operand_pkt_t in_pkt,
  output logic                       in_ack,
  output logic                       res_req,
  output logic signed [acc_w-1:0]    res_sum,
  input  logic                       res_ack,
  output logic                       adv,
  output mac_arith_pkg::operand_t    a,
  output mac_arith_pkg::operand_t    b,
  output mac_link_pkg::mac_tag_t     tag_in,
  input  logic signed [acc_w-1:0]    acc_sum,
  input  mac_link_pkg::mac_tag_t     acc_tag
);

  logic capture;    // Accept the pair on this edge
  logic res_take;   // Closing item leaves the accumulator

  assign adv      = !res_req && !res_ack;   // Result port idle
  assign capture  = in_req && !in_ack && adv;
  assign res_take = adv && acc_tag.valid && acc_tag.last;

  ////////////////////////////////////////////////////////////////////////////
  // Input port and issue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_ack <= 1'b0;
      tag_in <= '0;
    end else begin
      if (capture) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;                     // Host released the request
      end
      if (adv) begin
        tag_in <= '{valid: capture, first: in_pkt.first, last: in_pkt.last};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      a <= in_pkt.a;
      b <= in_pkt.b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      res_req <= 1'b0;
    end else if (res_take) begin
      res_req <= 1'b1;
    end else if (res_ack) begin
      res_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (res_take) begin
      res_sum <= acc_sum;
    end
  end

  a_ack_after_req : assert property (@(posedge clk) disable iff (!rstn)
    $rose(in_ack) |-> $past(in_req));

  a_res_stable : assert property (@(posedge clk) disable iff (!rstn)
    res_req |=> !res_req || $stable(res_sum));

endmodule

// File: source/pe_mac_top.sv
////////////////////////////////////////////////////////////////////////////
// MAC processing element top level
// Flow control in front of the signed multiplier and the accumulator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pe_mac_top #(
  parameter int acc_w = mac_arith_pkg::ACC_W_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       in_req,
  input  mac_link_pkg::operand_pkt_t in_pkt,
  output logic                       in_ack,
  output logic                       res_req,
  output logic signed [acc_w-1:0]    res_sum,
  input  logic                       res_ack
);

  import mac_arith_pkg::*;
  import mac_link_pkg::*;

  logic                    adv;        // Pipeline advance
  operand_t                a;
  operand_t                b;
  mac_tag_t                tag_in;
  product_t                prod;
  mac_tag_t                prod_tag;
  logic signed [acc_w-1:0] acc_sum;
  mac_tag_t                acc_tag;

  mac_flow_ctrl #(
    .acc_w (acc_w)
  ) u_ctrl (
    .clk     (clk),
    .rstn    (rstn),
    .in_req  (in_req),
    .in_pkt  (in_pkt),
    .in_ack  (in_ack),
    .res_req (res_req),
    .res_sum (res_sum),
    .res_ack (res_ack),
    .adv     (adv),
    .a       (a),
    .b       (b),
    .tag_in  (tag_in),
    .acc_sum (acc_sum),
    .acc_tag (acc_tag)
  );

  signed_mul_pipe u_mul (
    .clk      (clk),
    .rstn     (rstn),
    .adv      (adv),
    .a        (a),
    .b        (b),
    .tag_in   (tag_in),
    .prod     (prod),
    .prod_tag (prod_tag)
  );

  mac_accumulator #(
    .acc_w (acc_w)
  ) u_acc (
    .clk      (clk),
    .rstn     (rstn),
    .adv      (adv),
    .prod     (prod),
    .prod_tag (prod_tag),
    .acc_sum  (acc_sum),
    .acc_tag  (acc_tag)
  );

endmodule

// File: test/tb_pe_mac.sv
////////////////////////////////////////////////////////////////////////////
// MAC processing element testbench
// Sends operand groups over the four-phase input port, answers the result
// port with a random delay and compares every sum with a reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pe_mac;

  import mac_arith_pkg::*;
  import mac_link_pkg::*;

  typedef logic signed [ACC_W_DEFAULT-1:0] acc_t;

  localparam int MAX_GRP = 20;

  // Worst case run length in items, groups and clock cycles
  localparam int MAX_ITEMS   = 10 + 12 * 20 + 10 * 6 + 12 * 20;
  localparam int MAX_GROUPS  = 10 + 12 + 10 + 12;
  localparam int WATCHDOG_NS = (MAX_ITEMS * 12 + MAX_GROUPS * 16 + 8 + 500) * 40;

  logic         clk;
  logic         rstn;
  logic         in_req;
  operand_pkt_t in_pkt;
  logic         in_ack;
  logic         res_req;
  acc_t         res_sum;
  logic         res_ack;

  int       seed = 61;
  int       checks;
  int       errors;
  int       checks0;
  int       errors0;
  int       tests;
  int       delay_max;              // Longest wait before res_ack
  string    test_name;
  acc_t     exp_q [$];              // Expected sums in group order
  operand_t grp_a [MAX_GRP];
  operand_t grp_b [MAX_GRP];

  // Every sign combination, the extremes and zero
  int sp_a [10] = '{3, -3, 3, -3, -128, -128, 127, 0, -1, 127};
  int sp_b [10] = '{5, 5, -5, -5, -128, 127, 127, -77, 0, -128};

  pe_mac_top #(
    .acc_w (ACC_W_DEFAULT)
  ) UUT (
    .clk     (clk),
    .rstn    (rstn),
    .in_req  (in_req),
    .in_pkt  (in_pkt),
    .in_ack  (in_ack),
    .res_req (res_req),
    .res_sum (res_sum),
    .res_ack (res_ack)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Sum of signed products of the current group, wrapped to 28 bits
  function automatic acc_t ref_mac(input int n);
    acc_t total;
    total = '0;
    for (int i = 0; i < n; i++) begin
      total = total + acc_t'(int'(grp_a[i]) * int'(grp_b[i]));
    end
    return total;
  endfunction

  task automatic check_sum(input string name, input acc_t exp, input acc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s expected %b actual %b", test_name, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host side of the input port
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_item(input operand_pkt_t pkt);
    @(posedge clk);
    in_pkt <= pkt;
    in_req <= 1'b1;
    do @(negedge clk); while (!in_ack);
    @(posedge clk);
    in_req <= 1'b0;
    do @(negedge clk); while (in_ack);   // Phase 4 closes the item
  endtask

  task automatic send_group(input int n);
    operand_pkt_t pkt;
    exp_q.push_back(ref_mac(n));
    for (int i = 0; i < n; i++) begin
      pkt.a     = grp_a[i];
      pkt.b     = grp_b[i];
      pkt.first = (i == 0);
      pkt.last  = (i == n - 1);
      send_item(pkt);
    end
  endtask

  task automatic make_random_group(input int n);
    for (int i = 0; i < n; i++) begin
      grp_a[i] = operand_t'($random(seed));
      grp_b[i] = operand_t'($random(seed));
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    checks0   = checks;
    errors0   = errors;
  endtask

  task automatic finish_test();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);          // Room for a stray extra result
    tests++;
    $display("%-20s %0d checks, %0d errors", test_name, checks - checks0,
             errors - errors0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin : responder
    int delay;
    forever begin
      @(negedge clk);
      if (res_req) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: result arrived with no group outstanding", test_name);
        end else begin
          check_sum(test_name, exp_q.pop_front(), res_sum);
        end
        @(posedge clk);
        delay = (delay_max == 0) ? 0 : {$random(seed)} % (delay_max + 1);
        repeat (delay) @(posedge clk);
        res_ack <= 1'b1;
        do @(negedge clk); while (res_req);
        @(posedge clk);
        res_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int n;
    rstn      = 1'b0;
    in_req    = 1'b0;
    in_pkt    = '0;
    res_ack   = 1'b0;
    delay_max = 0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    start_test("reset");
    @(negedge clk);
    check_flag("in_ack", 1'b0, in_ack);
    check_flag("res_req", 1'b0, res_req);
    repeat (12) @(negedge clk);           // Empty pipeline gives no result
    check_flag("idle res_req", 1'b0, res_req);
    finish_test();

    start_test("single products");
    for (int i = 0; i < 10; i++) begin
      grp_a[0] = operand_t'(sp_a[i]);
      grp_b[0] = operand_t'(sp_b[i]);
      send_group(1);
    end
    finish_test();

    start_test("accumulation");
    repeat (12) begin
      n = 2 + {$random(seed)} % 19;
      make_random_group(n);
      send_group(n);
    end
    finish_test();

    // Short groups keep the next group in flight behind each result
    start_test("first restarts sum");
    repeat (10) begin
      n = 2 + {$random(seed)} % 5;
      make_random_group(n);
      send_group(n);
    end
    finish_test();

    start_test("back-pressure");
    delay_max = 15;
    repeat (12) begin
      n = 2 + {$random(seed)} % 19;
      make_random_group(n);
      send_group(n);
    end
    finish_test();
    check_flag("no extra result", 1'b0, res_req);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: pe_mac.f
source/mac_arith_pkg.sv
source/mac_link_pkg.sv
source/cla4_block.sv
source/cla_adder.sv
source/signed_mul_pipe.sv
source/mac_accumulator.sv
source/mac_flow_ctrl.sv
source/pe_mac_top.sv
test/tb_pe_mac.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MAC processing element testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pe_mac -f pe_mac.f \
  -Mdir obj_dir -o sim_pe_mac
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_pe_mac)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
